/* hw/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit import mipsPkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [4:0]  shamt,
    input  aluOpT       op,
    output logic [31:0] result,
    output logic        zero
);

    logic [31:0] product;

    // Only the low word of the product is kept
    assign product = a * b;

    always_comb begin
        case (op)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr:  result = a | b;
            aluXor: result = a ^ b;
            aluNor: result = ~(a | b);
            aluSlt: result = {31'd0, $signed(a) < $signed(b)};
            // Shifts act on the rt operand
            aluSll: result = b << shamt;
            aluSrl: result = b >> shamt;
            aluMul: result = product;
            default: result = '0;
        endcase
    end

    // Feeds branch resolution
    assign zero = (result == '0);

endmodule

/* hw/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit import mipsPkg::*; (
    input  logic [31:0] instr,
    output ctrlT        ctrl
);

    opcodeT opcode;
    functT  funct;

    assign opcode = opcodeT'(instr[31:26]);
    assign funct  = functT'(instr[5:0]);

    always_comb begin
        // Anything not listed below falls through as a no-op
        ctrl = '0;
        case (opcode)
            ////////////////////
            // R-type group
            opSpecial: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDstRd = 1'b1;
                case (funct)
                    functAdd: ctrl.aluOp = aluAdd;
                    functSub: ctrl.aluOp = aluSub;
                    functAnd: ctrl.aluOp = aluAnd;
                    functOr:  ctrl.aluOp = aluOr;
                    functXor: ctrl.aluOp = aluXor;
                    functNor: ctrl.aluOp = aluNor;
                    functSlt: ctrl.aluOp = aluSlt;
                    functMul: ctrl.aluOp = aluMul;
                    functSll: begin
                        ctrl.aluOp        = aluSll;
                        ctrl.shiftByShamt = 1'b1;
                    end
                    functSrl: begin
                        ctrl.aluOp        = aluSrl;
                        ctrl.shiftByShamt = 1'b1;
                    end
                    functJr: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.regDstRd = 1'b0;
                        ctrl.jumpReg  = 1'b1;
                    end
                    default: ctrl = '0;
                endcase
            end

            ////////////////////
            // Immediate ALU ops, result to rt
            opAddi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluAdd;
            end
            opSlti: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluSlt;
            end
            opAndi, opOri, opXori: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrcImm  = 1'b1;
                ctrl.zeroExtImm = 1'b1;
                ctrl.aluOp      = (opcode == opAndi) ? aluAnd :
                                  (opcode == opOri)  ? aluOr  : aluXor;
            end

            ////////////////////
            // Loads and stores, address is rs + simm
            opLw, opLh, opLb: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memSize   = (opcode == opLw) ? memWord :
                                 (opcode == opLh) ? memHalf : memByte;
            end
            opSw, opSh, opSb: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.memSize   = (opcode == opSw) ? memWord :
                                 (opcode == opSh) ? memHalf : memByte;
            end

            ////////////////////
            // Control flow
            opBeq: begin
                ctrl.aluOp    = aluSub;
                ctrl.branchEq = 1'b1;
            end
            opBne: begin
                ctrl.aluOp    = aluSub;
                ctrl.branchNe = 1'b1;
            end
            opJ: ctrl.jump = 1'b1;
            opJal: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // Checked on every new instruction word
    assert property (@(instr) !(ctrl.memWrite && ctrl.regWrite))
        else $error("controlUnit: store also writes a register");
    assert property (@(instr) !(ctrl.jump && (ctrl.branchEq || ctrl.branchNe)))
        else $error("controlUnit: jump and branch decoded together");

endmodule

/* hw/dataMemory.sv */
`timescale 1ns/1ps

module dataMemory import mipsPkg::*; #(
    parameter int dmemWords = 64
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] addr,
    input  logic [31:0] writeData,
    input  memSizeT     size,
    input  logic        writeEn,
    input  logic        readEn,
    output logic [31:0] readData,
    output logic [3:0]  byteEn
);

    localparam int idxW = $clog2(dmemWords);

    logic [31:0]     mem [dmemWords];
    logic [idxW-1:0] wordIdx;
    logic [31:0]     laneData;
    logic [31:0]     word;
    logic [15:0]     loadHalf;
    logic [7:0]      loadByte;

    // Little-endian lanes, address wraps past the top word
    assign wordIdx  = addr[idxW+1:2];
    assign laneData = alignStore(writeData, size);

    always_comb begin
        case (size)
            memHalf: byteEn = addr[1] ? 4'b1100 : 4'b0011;
            memByte: byteEn = 4'b0001 << addr[1:0];
            default: byteEn = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (writeEn) begin
            for (int i = 0; i < 4; i++) begin
                if (byteEn[i]) begin
                    mem[wordIdx][8*i +: 8] <= laneData[8*i +: 8];
                end
            end
        end
    end

    // Load path, halves and bytes are sign-extended
    assign word     = mem[wordIdx];
    assign loadHalf = addr[1] ? word[31:16] : word[15:0];
    assign loadByte = word[8*addr[1:0] +: 8];

    always_comb begin
        readData = '0;
        if (readEn) begin
            case (size)
                memHalf: readData = {{16{loadHalf[15]}}, loadHalf};
                memByte: readData = {{24{loadByte[7]}}, loadByte};
                default: readData = word;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        ((writeEn || readEn) && size == memWord) |-> (addr[1:0] == 2'b00))
        else $error("dataMemory: unaligned word access at %h", addr);
    assert property (@(posedge clk) disable iff (!rstN)
        ((writeEn || readEn) && size == memHalf) |-> (addr[0] == 1'b0))
        else $error("dataMemory: unaligned half access at %h", addr);

endmodule

/* hw/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; #(
    parameter int imemWords = 64,
    parameter int dmemWords = 64
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         loadValid,
    input  logic [$clog2(imemWords)-1:0] loadAddr,
    input  logic [31:0]                  loadData,
    input  logic                         runEn,
    output wbTraceT                      wbTrace,
    output memTraceT                     memTrace
);

    localparam int imemAw = $clog2(imemWords);

    logic [31:0] imem [imemWords];
    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] pcNext;
    logic [31:0] instr;
    ctrlT        ctrl;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] immExt;
    logic [31:0] aluB;
    logic [4:0]  shamt;
    logic [31:0] aluResult;
    logic        aluZero;
    logic [31:0] loadValue;
    logic [3:0]  byteEn;
    logic [4:0]  writeReg;
    logic [31:0] writeData;
    logic        regWriteEn;
    logic        memWriteEn;
    logic        branchTaken;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;

    ////////////////////
    // Program memory and fetch
    always_ff @(posedge clk) begin
        if (loadValid) begin
            imem[loadAddr] <= loadData;
        end
    end

    assign instr   = imem[pc[imemAw+1:2]];
    assign pcPlus4 = pc + 32'd4;

    controlUnit ctrlDec (.instr(instr), .ctrl(ctrl));

    // Writes are held off while the core is stopped
    assign regWriteEn = ctrl.regWrite && runEn;
    assign memWriteEn = ctrl.memWrite && runEn;

    registerFile regs (
        .clk(clk), .rstN(rstN),
        .readAddrA(instr[25:21]), .readAddrB(instr[20:16]),
        .readDataA(rsData), .readDataB(rtData),
        .writeEn(regWriteEn), .writeAddr(writeReg), .writeData(writeData)
    );

    ////////////////////
    // Execute
    assign immExt = ctrl.zeroExtImm ? {16'd0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign aluB   = ctrl.aluSrcImm ? immExt : rtData;
    assign shamt  = ctrl.shiftByShamt ? instr[10:6] : 5'd0;

    aluUnit alu (
        .a(rsData), .b(aluB), .shamt(shamt), .op(ctrl.aluOp),
        .result(aluResult), .zero(aluZero)
    );

    dataMemory #(.dmemWords(dmemWords)) dmem (
        .clk(clk), .rstN(rstN), .addr(aluResult), .writeData(rtData),
        .size(ctrl.memSize), .writeEn(memWriteEn), .readEn(ctrl.memRead),
        .readData(loadValue), .byteEn(byteEn)
    );

    // Write-back select
    assign writeReg  = ctrl.link ? linkReg : (ctrl.regDstRd ? instr[15:11] : instr[20:16]);
    assign writeData = ctrl.link ? pcPlus4 : (ctrl.memRead ? loadValue : aluResult);

    ////////////////////
    // Next PC
    assign branchTaken  = (ctrl.branchEq && aluZero) || (ctrl.branchNe && !aluZero);
    assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};
    assign pcNext = ctrl.jumpReg ? rsData :
                    ctrl.jump    ? jumpTarget :
                    branchTaken  ? branchTarget : pcPlus4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (runEn) begin
            pc <= pcNext;
        end
    end

    // Trace entries, one cycle after the instruction retires
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbTrace  <= '0;
            memTrace <= '0;
        end else begin
            wbTrace.valid   <= regWriteEn && (writeReg != 5'd0);
            wbTrace.regAddr <= writeReg;
            wbTrace.data    <= writeData;
            memTrace.valid  <= memWriteEn;
            memTrace.addr   <= aluResult;
            memTrace.data   <= alignStore(rtData, ctrl.memSize);
            memTrace.byteEn <= byteEn;
        end
    end

endmodule

/* hw/mipsPkg.sv */
package mipsPkg;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddi    = 6'h08,
        opSlti    = 6'h0a,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opXori    = 6'h0e,
        opLb      = 6'h20,
        opLh      = 6'h21,
        opLw      = 6'h23,
        opSb      = 6'h28,
        opSh      = 6'h29,
        opSw      = 6'h2b
    } opcodeT;

    // Function field of the R-type group, instr[5:0]
    typedef enum logic [5:0] {
        functSll = 6'h00,
        functSrl = 6'h02,
        functJr  = 6'h08,
        functMul = 6'h1c,
        functAdd = 6'h20,
        functSub = 6'h22,
        functAnd = 6'h24,
        functOr  = 6'h25,
        functXor = 6'h26,
        functNor = 6'h27,
        functSlt = 6'h2a
    } functT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSll,
        aluSrl,
        aluMul
    } aluOpT;

    typedef enum logic [1:0] {
        memWord,
        memHalf,
        memByte
    } memSizeT;

    typedef struct packed {
        logic    regWrite;
        aluOpT   aluOp;
        logic    aluSrcImm;
        logic    zeroExtImm;
        logic    regDstRd;
        logic    link;
        logic    memWrite;
        logic    memRead;
        memSizeT memSize;
        logic    branchEq;
        logic    branchNe;
        logic    jump;
        logic    jumpReg;
        logic    shiftByShamt;
    } ctrlT;

    typedef struct packed {
        logic        valid;
        logic [4:0]  regAddr;
        logic [31:0] data;
    } wbTraceT;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  byteEn;
    } memTraceT;

    // JAL return address register
    localparam logic [4:0] linkReg = 5'd31;

    // Store data copied onto every lane, byte enables pick the lanes
    function automatic logic [31:0] alignStore(input logic [31:0] data, input memSizeT size);
        case (size)
            memHalf: return {2{data[15:0]}};
            memByte: return {4{data[7:0]}};
            default: return data;
        endcase
    endfunction

endpackage

/* hw/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  readAddrA,
    input  logic [4:0]  readAddrB,
    output logic [31:0] readDataA,
    output logic [31:0] readDataB,
    input  logic        writeEn,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData
);

    logic [31:0] regs [32];

    // Combinational read ports
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != 5'd0) begin
            // Register 0 stays zero
            regs[writeAddr] <= writeData;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        (readAddrA == 5'd0) |-> (readDataA == '0))
        else $error("registerFile: register 0 read nonzero on port A");
    assert property (@(posedge clk) disable iff (!rstN)
        (readAddrB == 5'd0) |-> (readDataB == '0))
        else $error("registerFile: register 0 read nonzero on port B");

endmodule

/* mipsCore.f */
hw/mipsPkg.sv
hw/controlUnit.sv
hw/aluUnit.sv
hw/registerFile.sv
hw/dataMemory.sv
hw/mipsCore.sv
testbench/clockGen.sv
testbench/mipsCoreTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it into a log and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert \
    --top-module mipsCoreTb -f mipsCore.f \
    --Mdir "$BUILD_DIR" -o mipsCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/mipsCoreSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "Run FAILED, see $LOG"
    exit 1
fi
echo "Run passed"
exit 0

/* testbench/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
    parameter int periodNs    = 8,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Reset drops on a falling edge, away from the DUT's active edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

/* testbench/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb import mipsPkg::*; ();

    localparam int imemWords  = 64;
    localparam int dmemWords  = 64;
    localparam int loadAw     = $clog2(imemWords);
    localparam int groupCount = 6;

    // Sections of the stimulus image
    localparam int groupBase = 'h04;
    localparam int progBase  = 'h10;
    localparam int wbBase    = 'h40;
    localparam int memBase   = 'h80;

    logic              clk;
    logic              rstN;
    logic              loadValid;
    logic [loadAw-1:0] loadAddr;
    logic [31:0]       loadData;
    logic              runEn;
    wbTraceT           wbTrace;
    memTraceT          memTrace;

    logic [31:0] image [256];
    logic        runEnQ;
    int progWords   = 0;
    int runLength   = 0;
    int wbCount     = 0;
    int memCount    = 0;
    int wbIdx       = 0;
    int memIdx      = 0;
    int errorCount  = 0;
    int failedTests = 0;
    int cycleCount  = 0;
    int cycleLimit  = 1000;

    clockGen #(.periodNs(8), .resetCycles(3)) clocks (.clk(clk), .rstN(rstN));

    mipsCore #(.imemWords(imemWords), .dmemWords(dmemWords)) DUT (
        .clk(clk), .rstN(rstN), .loadValid(loadValid), .loadAddr(loadAddr),
        .loadData(loadData), .runEn(runEn), .wbTrace(wbTrace), .memTrace(memTrace)
    );

    function automatic logic [31:0] imageAt(input int index);
        return image[8'(index)];
    endfunction

    function automatic string testName(input int test);
        case (test)
            0: return "idle during reset and loading";
            1: return "R-type ALU";
            2: return "immediate extension";
            3: return "stores and loads";
            4: return "BEQ and BNE";
            5: return "J, JAL and JR";
            default: return "register zero";
        endcase
    endfunction

    task automatic reportTest(input int test, input int errors);
        if (errors == 0) begin
            $display("Test %0d %s: pass", test, testName(test));
        end else begin
            $display("Test %0d %s: FAIL with %0d errors", test, testName(test), errors);
            failedTests++;
        end
    endtask

    ////////////////////
    // Trace checking

    // Index of the next expected entry moves on as each entry ends
    always @(posedge clk) begin
        if (wbTrace.valid) begin
            wbIdx <= wbIdx + 1;
        end
        if (memTrace.valid) begin
            memIdx <= memIdx + 1;
        end
    end

    // runEn of the cycle that a trace entry reports on
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            runEnQ <= 1'b0;
        end else begin
            runEnQ <= runEn;
        end
    end

    // Entries are stable between rising edges, so all checks sample on the falling edge
    assert property (@(negedge clk) !runEnQ |-> !(wbTrace.valid || memTrace.valid))
    else begin
        $display("Trace entry appeared while the core was stopped");
        errorCount++;
    end

    assert property (@(negedge clk) disable iff (!rstN) wbTrace.valid |-> (wbIdx < wbCount))
    else begin
        $display("Write-back to register %0d beyond the expected list", wbTrace.regAddr);
        errorCount++;
    end

    assert property (@(negedge clk) disable iff (!rstN)
        (wbTrace.valid && wbIdx < wbCount) |->
            ({27'd0, wbTrace.regAddr} == imageAt(wbBase + 2 * wbIdx) &&
             wbTrace.data == imageAt(wbBase + 2 * wbIdx + 1)))
    else begin
        $display("Mismatch wbTrace entry %0d: expected reg %h data %h, got reg %h data %h",
                 wbIdx, imageAt(wbBase + 2 * wbIdx), imageAt(wbBase + 2 * wbIdx + 1),
                 wbTrace.regAddr, wbTrace.data);
        errorCount++;
    end

    assert property (@(negedge clk) disable iff (!rstN) memTrace.valid |-> (memIdx < memCount))
    else begin
        $display("Store to address %h beyond the expected list", memTrace.addr);
        errorCount++;
    end

    assert property (@(negedge clk) disable iff (!rstN)
        (memTrace.valid && memIdx < memCount) |->
            (memTrace.addr == imageAt(memBase + 3 * memIdx) &&
             memTrace.data == imageAt(memBase + 3 * memIdx + 1) &&
             {28'd0, memTrace.byteEn} == imageAt(memBase + 3 * memIdx + 2)))
    else begin
        $display("Mismatch memTrace entry %0d: expected addr %h data %h byteEn %h",
                 memIdx, imageAt(memBase + 3 * memIdx), imageAt(memBase + 3 * memIdx + 1),
                 imageAt(memBase + 3 * memIdx + 2));
        $display("Mismatch memTrace entry %0d: got addr %h data %h byteEn %h",
                 memIdx, memTrace.addr, memTrace.data, memTrace.byteEn);
        errorCount++;
    end

    ////////////////////
    // Stimulus
    initial begin
        int i;
        int test;
        int gap;
        int startErrors;
        loadValid = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        runEn     = 1'b0;
        void'($urandom(39));
        $readmemh("testbench/program.hex", image);
        progWords = imageAt(0);
        runLength = imageAt(1);
        wbCount   = imageAt(2);
        memCount  = imageAt(3);
        // Reset plus at most four cycles per loaded word
        cycleLimit = 2 * runLength + 4 * progWords + 8;

        @(posedge rstN);
        @(negedge clk);
        for (i = 0; i < progWords; i++) begin
            gap = $urandom % 4;
            repeat (gap) @(negedge clk);
            loadValid = 1'b1;
            loadAddr  = loadAw'(i);
            loadData  = imageAt(progBase + i);
            @(negedge clk);
            loadValid = 1'b0;
        end
        @(negedge clk);
        reportTest(0, errorCount);

        runEn = 1'b1;
        startErrors = errorCount;
        for (test = 1; test <= groupCount; test++) begin
            while (wbIdx < imageAt(groupBase + 2 * (test - 1)) ||
                   memIdx < imageAt(groupBase + 2 * (test - 1) + 1)) begin
                @(negedge clk);
            end
            reportTest(test, errorCount - startErrors);
            startErrors = errorCount;
        end

        // Core now spins on its final jump, nothing more may appear
        repeat (4) @(negedge clk);
        $display("Tests run %0d, failed %0d, errors %0d",
                 groupCount + 1, failedTests, errorCount);
        if (errorCount == 0 && failedTests == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles with %0d of %0d write-backs and %0d of %0d stores",
                     cycleCount, wbIdx, wbCount, memIdx, memCount);
            $display("Something failed");
            $finish;
        end
    end

endmodule

/* testbench/program.hex */
// @00 program words, run length, write-back count, store count; @04 group ends (wb, store)
// @10 program; @40 write-back pairs (reg, data); @80 store triples (addr, data, byteEn)
@00 0000002B 00000026 0000001C 00000003
@04 0000000D 00000000 00000013 00000000 00000017 00000003 00000019 00000003 0000001B 00000003
    0000001C 00000003
@10 20010007 2002FFFD 00221820 00222022 00222824 00223025 00223826 00224027
    0041482A 0022502A 0022581C 00016100 00026F02 304EFF00 340F8001 3850FFFF
    2031FFF6 2832FFFF 2853FFFE 20140040 AE820000 A68F0006 A2870009 8E950000
    86960006 82970009 10210001 20180001 10220001 20180002 14220001 20190003
    14210001 20190004 0C000025 08000028 201A0005 201A0006 03E00008 201B0007
    20000005 0001E020 0800002A
@40 00000001 00000007 00000002 FFFFFFFD 00000003 00000004 00000004 0000000A
    00000005 00000005 00000006 FFFFFFFF 00000007 FFFFFFFA 00000008 00000000
    00000009 00000001 0000000A 00000000 0000000B FFFFFFEB 0000000C 00000070
    0000000D 0000000F 0000000E 0000FF00 0000000F 00008001 00000010 FFFF0002
    00000011 FFFFFFFD 00000012 00000000 00000013 00000001 00000014 00000040
    00000015 FFFFFFFD 00000016 FFFF8001 00000017 FFFFFFFA 00000018 00000002
    00000019 00000004 0000001F 0000008C 0000001A 00000006 0000001C 00000007
@80 00000040 FFFFFFFD 0000000F
    00000046 80018001 0000000C
    00000049 FAFAFAFA 00000002
